/* Makefile */
# Verilator build and run for the voice read path testbench

TOP = tb_spuVoice

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -o V$(TOP)

# The run passes only if the pass line shows up in the simulator output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^PASS: all tests$$'

clean:
	rm -rf obj_dir

/* all.f */
hw/voicePkg.sv
hw/interpIf.sv
hw/kernelRom.sv
hw/sampleRing.sv
hw/pitchCounter.sv
hw/gaussInterp.sv
hw/voiceCtrl.sv
hw/spuVoiceTop.sv
testbench/voice_assert.sv
testbench/voiceMonitor.sv
testbench/tb_spuVoice.sv

/* hw/gaussInterp.sv */
// ****************************************
// Four tap kernel interpolator
// Walks ROM and ring, sums weighted taps
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module gaussInterp import voicePkg::*; (
	input  wire                         i_clk,
	input  wire                         i_rst,
	interpIf.interp                     ipBus,
	output logic       [RING_ADR_W-1:0] o_ringAdr,
	input  wire signed [SAMPLE_W-1:0]   i_ringData
);

	// Run index, 0 during go, parks at 7 when idle
	logic [2:0] idxReg;
	logic [2:0] idx;

	// Kernel side
	logic [ROM_ADR_W-1:0] romAdr;
	logic signed [SAMPLE_W-1:0] weight;

	// Ring side
	logic [RING_ADR_W-1:0] tapOff;
	logic [RING_ADR_W-1:0] tapAdr;
	logic [2:0] blockSel;

	// Weighted tap and running sum
	logic signed [2*SAMPLE_W-1:0] product;
	logic signed [SAMPLE_W-1:0] term;
	logic signed [ACC_W-1:0] acc;

	// Go cycle issues the first tap so valid lands 5 cycles later
	assign idx = ipBus.go ? 3'd0 : idxReg;

	// Tap order is newest, old, oldest, older
	// idx[0] picks the ROM half, idx[1] mirrors the phase
	//   0  phase
	//   1  256 + phase
	//   2  255 - phase
	//   3  511 - phase
	assign romAdr = {idx[0], idx[1] ? ~ipBus.phase : ipBus.phase};

	kernelRom u_kernelRom (
		.i_clk    (i_clk),
		.i_adr    (romAdr),
		.o_weight (weight)
	);

	// Ring offsets 0, -1, -3, -2 in five bit wrap
	always_comb begin
		case (idx[1:0])
			2'd0: tapOff = 5'd0;
			2'd1: tapOff = 5'd31;
			2'd2: tapOff = 5'd29;
			default: tapOff = 5'd30;
		endcase
	end

	assign tapAdr = ipBus.newPos + tapOff;

	// Ring has blocks 0 to 6 only
	// anything that lands in block 7 reads block 6
	assign blockSel = (tapAdr[4:2] == 3'd7) ? 3'd6 : tapAdr[4:2];
	assign o_ringAdr = {blockSel, tapAdr[1:0]};

	// ROM and ring both return one cycle late
	// so the pair at their outputs belongs to the previous index
	assign product = weight * i_ringData;
	// Divide by 2^15 and keep 16 bits, no rounding or clamp
	assign term = product[SAMPLE_W+KERNEL_SHIFT-1:KERNEL_SHIFT];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			idxReg <= 3'd7;
		end else if (ipBus.go) begin
			idxReg <= 3'd1;
		end else if (idxReg != 3'd7) begin
			// Runs on to 7 and waits for the next go
			idxReg <= idxReg + 3'd1;
		end
	end

	// Taps 0 to 3 arrive while idxReg is 1 to 4
	always_ff @(posedge i_clk) begin
		if (ipBus.go) begin
			acc <= '0;
		end else if ((idxReg >= 3'd1) && (idxReg <= 3'd4)) begin
			acc <= acc + ACC_W'(term);
		end
	end

	// Sum is complete once the fourth tap is in
	assign ipBus.valid = (idxReg == 3'd5);
	// Result wraps to 16 bits
	assign ipBus.sample = acc[SAMPLE_W-1:0];

endmodule

`default_nettype wire

/* hw/interpIf.sv */
// ****************************************
// Controller to interpolator link
// ****************************************
`timescale 1ns/1ps
`default_nettype none

interface interpIf import voicePkg::*; ();

	// Run request and its operands, held from go until valid
	logic go;
	logic [PHASE_W-1:0] phase;
	logic [RING_ADR_W-1:0] newPos;

	// One cycle result pulse
	logic valid;
	logic signed [SAMPLE_W-1:0] sample;

	modport ctrl (output go, output phase, output newPos, input valid, input sample);
	modport interp (input go, input phase, input newPos, output valid, output sample);

endinterface

`default_nettype wire

/* hw/kernelRom.sv */
// ****************************************
// Interpolation kernel ROM, 512 x 16
// Cubic B-spline weights, one clock latency
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module kernelRom import voicePkg::*; (
	input  wire                       i_clk,
	input  wire       [ROM_ADR_W-1:0] i_adr,
	output logic signed [SAMPLE_W-1:0] o_weight
);

	// Weight for entry k
	// Low half is the outer spline piece t^3 / 6
	// High half is the middle piece of the same spline
	function automatic logic signed [SAMPLE_W-1:0] kernelWeight(input int k);
		longint half;
		longint t;
		longint one;
		longint num;
		half = longint'(2) ** (ROM_ADR_W - 1);
		one = longint'(1) << 24;
		t = longint'(k) % half;
		if (k < half) begin
			num = t * t * t;
		end else begin
			num = -3 * t * t * t + 768 * t * t + 196608 * t + one;
		end
		// Scale to Q15 and divide by 6 * 2^24, truncating
		return SAMPLE_W'((num << KERNEL_SHIFT) / (6 * one));
	endfunction

	logic signed [SAMPLE_W-1:0] romTable [2**ROM_ADR_W];

	// Table contents are constants, fixed at elaboration
	for (genvar k = 0; k < 2**ROM_ADR_W; k++) begin : g_fill
		assign romTable[k] = kernelWeight(k);
	end

	// Registered read, maps onto a block RAM
	always_ff @(posedge i_clk) begin
		o_weight <= romTable[i_adr];
	end

endmodule

`default_nettype wire

/* hw/pitchCounter.sv */
// ****************************************
// Voice pitch counter
// 5.12 fixed point position, wraps at 28
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module pitchCounter import voicePkg::*; (
	input  wire                   i_clk,
	input  wire                   i_rst,
	input  wire                   i_load,
	input  wire                   i_step,
	input  wire  [PITCH_W-1:0]    i_pitch,
	output logic [RING_ADR_W-1:0] o_newPos,
	output logic [PHASE_W-1:0]    o_phase
);

	// Integer sample index and sub-sample fraction
	logic [RING_ADR_W-1:0] intPos;
	logic [FRAC_W-1:0] frac;

	// Fraction plus pitch, top bits carry up to four samples
	logic [FRAC_W+2:0] fracSum;
	logic [2:0] carry;
	logic [RING_ADR_W-1:0] intSum;
	logic [RING_ADR_W-1:0] intNext;

	assign fracSum = (FRAC_W + 3)'(frac) + (FRAC_W + 3)'(i_pitch);
	assign carry = fracSum[FRAC_W+2:FRAC_W];

	// Largest sum is 27 + 4, still inside five bits
	assign intSum = intPos + RING_ADR_W'(carry);

	// Wrap modulo the ring depth
	assign intNext = (intSum >= RING_ADR_W'(RING_DEPTH)) ?
		intSum - RING_ADR_W'(RING_DEPTH) : intSum;

	always_ff @(posedge i_clk) begin
		if (i_rst || i_load) begin
			intPos <= RING_ADR_W'(START_POS);
			frac <= '0;
		end else if (i_step) begin
			intPos <= intNext;
			frac <= fracSum[FRAC_W-1:0];
		end
	end

	assign o_newPos = intPos;
	// Kernel phase is the fraction's top bits
	assign o_phase = frac[FRAC_W-1 -: PHASE_W];

endmodule

`default_nettype wire

/* hw/sampleRing.sv */
// ****************************************
// Voice sample ring, 28 words
// External write, registered read
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module sampleRing import voicePkg::*; (
	input  wire                         i_clk,
	input  wire                         i_wrEn,
	input  wire        [RING_ADR_W-1:0] i_wrAdr,
	input  wire signed [SAMPLE_W-1:0]   i_wrData,
	input  wire        [RING_ADR_W-1:0] i_rdAdr,
	output logic signed [SAMPLE_W-1:0]  o_rdData
);

	// Seven blocks of four decoded samples
	logic signed [SAMPLE_W-1:0] ring [RING_DEPTH];

	// Writes land at the next edge
	// Addresses in block 7 do not exist and are dropped
	always_ff @(posedge i_clk) begin
		if (i_wrEn && (i_wrAdr < RING_ADR_W'(RING_DEPTH))) begin
			ring[i_wrAdr] <= i_wrData;
		end
	end

	// One cycle read latency, matches the kernel ROM
	// Read address is already folded out of block 7 by the interpolator
	always_ff @(posedge i_clk) begin
		o_rdData <= ring[i_rdAdr];
	end

endmodule

`default_nettype wire

/* hw/spuVoiceTop.sv */
// ****************************************
// Single voice read path, top level
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module spuVoiceTop import voicePkg::*; (
	input  wire                         i_clk,
	input  wire                         i_rst,
	input  wire                         i_start,
	input  wire                         i_tick,
	input  wire        [PITCH_W-1:0]    i_pitch,
	input  wire                         i_wrEn,
	input  wire        [RING_ADR_W-1:0] i_wrAdr,
	input  wire signed [SAMPLE_W-1:0]   i_wrData,
	output logic signed [SAMPLE_W-1:0]  o_sample,
	output logic                        o_valid,
	output logic                        o_tickLost
);

	// Counter control and position
	logic load;
	logic step;
	logic [RING_ADR_W-1:0] newPos;
	logic [PHASE_W-1:0] phase;

	// Ring read port
	logic [RING_ADR_W-1:0] ringAdr;
	logic signed [SAMPLE_W-1:0] ringData;

	interpIf ipBus ();

	voiceCtrl u_voiceCtrl (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_start    (i_start),
		.i_tick     (i_tick),
		.i_newPos   (newPos),
		.i_phase    (phase),
		.o_load     (load),
		.o_step     (step),
		.o_tickLost (o_tickLost),
		.o_sample   (o_sample),
		.o_valid    (o_valid),
		.ipBus      (ipBus.ctrl)
	);

	pitchCounter u_pitchCounter (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_load   (load),
		.i_step   (step),
		.i_pitch  (i_pitch),
		.o_newPos (newPos),
		.o_phase  (phase)
	);

	gaussInterp u_gaussInterp (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.ipBus      (ipBus.interp),
		.o_ringAdr  (ringAdr),
		.i_ringData (ringData)
	);

	// Decoded samples come in from outside
	sampleRing u_sampleRing (
		.i_clk    (i_clk),
		.i_wrEn   (i_wrEn),
		.i_wrAdr  (i_wrAdr),
		.i_wrData (i_wrData),
		.i_rdAdr  (ringAdr),
		.o_rdData (ringData)
	);

endmodule

`default_nettype wire

/* hw/voiceCtrl.sv */
// ****************************************
// Voice control FSM
// Ticks to interpolator runs and steps
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module voiceCtrl import voicePkg::*; (
	input  wire                         i_clk,
	input  wire                         i_rst,
	input  wire                         i_start,
	input  wire                         i_tick,
	input  wire        [RING_ADR_W-1:0] i_newPos,
	input  wire        [PHASE_W-1:0]    i_phase,
	output logic                        o_load,
	output logic                        o_step,
	output logic                        o_tickLost,
	output logic signed [SAMPLE_W-1:0]  o_sample,
	output logic                        o_valid,
	interpIf.ctrl                       ipBus
);

	typedef enum logic [1:0] {
		IDLE,
		ARMED,
		RUN,
		ADVANCE
	} stateT;

	stateT state;
	stateT stateNext;

	logic startDly;
	logic accept;
	logic busy;

	// Run request and the operands frozen for it
	logic goReg;
	logic [PHASE_W-1:0] phaseReg;
	logic [RING_ADR_W-1:0] posReg;

	// Last result, kept for the output between runs
	logic signed [SAMPLE_W-1:0] sampleHold;

	// Start edge reloads the position, only from idle
	assign o_load = (state == IDLE) && i_start && !startDly;

	// Tick is taken only when armed and started
	assign accept = (state == ARMED) && i_start && i_tick;

	// Busy from go until the cycle after valid
	assign busy = (state == RUN) || (state == ADVANCE);
	assign o_tickLost = busy && i_start && i_tick;

	// Counter moves once per run, after the result is out
	assign o_step = (state == ADVANCE);

	always_comb begin
		stateNext = state;
		case (state)
			IDLE: if (o_load) stateNext = ARMED;
			ARMED: begin
				if (!i_start) stateNext = IDLE;
				else if (i_tick) stateNext = RUN;
			end
			RUN: if (ipBus.valid) stateNext = ADVANCE;
			default: stateNext = i_start ? ARMED : IDLE;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= IDLE;
			startDly <= 1'b0;
			goReg <= 1'b0;
		end else begin
			state <= stateNext;
			startDly <= i_start;
			goReg <= accept;
		end
	end

	// Operands are sampled with the tick and held through the run
	always_ff @(posedge i_clk) begin
		if (accept) begin
			phaseReg <= i_phase;
			posReg <= i_newPos;
		end
		if (ipBus.valid) begin
			sampleHold <= ipBus.sample;
		end
	end

	assign ipBus.go = goReg;
	assign ipBus.phase = phaseReg;
	assign ipBus.newPos = posReg;

	// Result leaves in the valid cycle, then the held copy stays on the port
	assign o_valid = ipBus.valid;
	assign o_sample = ipBus.valid ? ipBus.sample : sampleHold;

endmodule

`default_nettype wire

/* hw/voicePkg.sv */
// ****************************************
// Voice read path constants
// Ring, position, sample and kernel widths
// ****************************************
`default_nettype none

package voicePkg;

	// Ring buffer of seven blocks of four samples
	localparam int RING_DEPTH = 28;
	localparam int RING_ADR_W = 5;

	// Position value right after a start
	localparam int START_POS = 3;

	// Fixed point position, 4096 is one whole sample
	localparam int FRAC_W = 12;
	// Top fraction bits select the kernel phase
	localparam int PHASE_W = 8;
	localparam int PITCH_W = 14;

	// Signed sample and accumulator
	localparam int SAMPLE_W = 16;
	localparam int ACC_W = 18;

	// Kernel scale, each product is shifted down by this
	localparam int KERNEL_SHIFT = 15;
	localparam int ROM_ADR_W = 9;

endpackage

`default_nettype wire

/* testbench/tb_spuVoice.sv */
// ****************************************
// Voice read path testbench
// Ring fill, start and tick stimulus
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module tb_spuVoice import voicePkg::*; ();

	logic clk;
	logic rst;
	logic start;
	logic tick;
	logic [PITCH_W-1:0] pitch;
	logic wrEn;
	logic [RING_ADR_W-1:0] wrAdr;
	logic signed [SAMPLE_W-1:0] wrData;
	logic signed [SAMPLE_W-1:0] sample;
	logic valid;
	logic tickLost;

	// Error and progress counts
	int mismatches;
	int checkedOut;
	int timeouts;
	int otherErrors;
	int assertFails;
	int runsDone;
	logic [31:0] rngState;

	always #2 clk = ~clk;

	spuVoiceTop u_spuVoiceTop (
		.i_clk      (clk),
		.i_rst      (rst),
		.i_start    (start),
		.i_tick     (tick),
		.i_pitch    (pitch),
		.i_wrEn     (wrEn),
		.i_wrAdr    (wrAdr),
		.i_wrData   (wrData),
		.o_sample   (sample),
		.o_valid    (valid),
		.o_tickLost (tickLost)
	);

	voiceMonitor u_voiceMonitor (
		.i_clk      (clk),
		.i_rst      (rst),
		.i_start    (start),
		.i_tick     (tick),
		.i_pitch    (pitch),
		.i_wrEn     (wrEn),
		.i_wrAdr    (wrAdr),
		.i_wrData   (wrData),
		.i_sample   (sample),
		.i_valid    (valid),
		.i_tickLost (tickLost),
		.o_errCount (mismatches),
		.o_checked  (checkedOut)
	);

	bind voiceCtrl voice_assert u_voiceAssert (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_go    (goReg),
		.i_valid (o_valid),
		.i_load  (o_load),
		.i_step  (o_step)
	);

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Mode 0 random, 1 full positive, 2 full negative, 3 mixed by address parity
	task automatic fillRing(input int mode);
		int adr;
		for (adr = 0; adr < RING_DEPTH; adr++) begin
			rngState = lcgNext(rngState);
			@(posedge clk);
			wrEn <= 1'b1;
			wrAdr <= RING_ADR_W'(adr);
			case (mode)
				0: wrData <= rngState[31:16];
				1: wrData <= 16'h7fff;
				2: wrData <= 16'h8000;
				default: wrData <= (^adr[RING_ADR_W-1:0]) ? 16'h8000 : 16'h7fff;
			endcase
		end
		@(posedge clk);
		wrEn <= 1'b0;
	endtask

	task automatic setPitch(input logic [PITCH_W-1:0] value);
		@(posedge clk);
		pitch <= value;
	endtask

	task automatic setStart(input logic level);
		@(posedge clk);
		start <= level;
	endtask

	// Waits for the result and one more edge so the next tick is accepted
	task automatic waitValid();
		int c;
		bit seen;
		seen = 1'b0;
		for (c = 0; (c < 16) && !seen; c++) begin
			@(negedge clk);
			seen = (valid === 1'b1);
		end
		if (seen) begin
			runsDone++;
		end else begin
			$display("Timeout at %0t: no o_valid within 16 cycles of a tick", $time);
			timeouts++;
		end
		@(posedge clk);
	endtask

	// One accepted tick and optionally a second one 3 cycles later while busy
	task automatic runTick(input bit withLost);
		@(posedge clk);
		tick <= 1'b1;
		@(posedge clk);
		tick <= 1'b0;
		if (withLost) begin
			@(posedge clk);
			@(posedge clk);
			tick <= 1'b1;
			@(posedge clk);
			tick <= 1'b0;
		end
		waitValid();
	endtask

	// Ticks with start low must give nothing
	task automatic idleTicks(input int n);
		int i;
		int c;
		for (i = 0; i < n; i++) begin
			@(posedge clk);
			tick <= 1'b1;
			@(posedge clk);
			tick <= 1'b0;
			for (c = 0; c < 8; c++) begin
				@(negedge clk);
				if (valid !== 1'b0) begin
					$display("Error at %0t: o_valid rose while start was low", $time);
					otherErrors++;
				end
			end
		end
	endtask

	initial begin
		int i;
		int mode;
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		tick = 1'b0;
		pitch = 14'd4096;
		wrEn = 1'b0;
		wrAdr = '0;
		wrData = '0;
		timeouts = 0;
		otherErrors = 0;
		assertFails = 0;
		runsDone = 0;
		rngState = 32'hd6c5;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		idleTicks(3);

		// One sample per tick so the phase stays 0
		fillRing(0);
		setPitch(14'd4096);
		setStart(1'b1);
		repeat (32) runTick(1'b0);

		// Fractional and large pitches that wrap past 27
		for (i = 0; i < 40; i++) begin
			rngState = lcgNext(rngState);
			setPitch(rngState[29:16]);
			runTick(1'b0);
		end
		setPitch(14'h3fff);
		repeat (4) runTick(1'b0);

		// Second tick lands while busy
		for (i = 0; i < 6; i++) begin
			rngState = lcgNext(rngState);
			setPitch(rngState[29:16]);
			runTick(1'b1);
		end

		// Restart goes back to sample 3
		setStart(1'b0);
		idleTicks(2);
		setPitch(14'd4096);
		setStart(1'b1);
		repeat (6) runTick(1'b0);

		// Full scale rings
		for (mode = 1; mode < 4; mode++) begin
			setStart(1'b0);
			fillRing(mode);
			setStart(1'b1);
			for (i = 0; i < 10; i++) begin
				rngState = lcgNext(rngState);
				setPitch(rngState[29:16]);
				runTick(1'b0);
			end
		end

		repeat (4) @(posedge clk);
		if (checkedOut != runsDone) begin
			$display("Error: monitor checked %0d outputs but %0d ticks produced one",
				checkedOut, runsDone);
			otherErrors++;
		end
		assertFails = u_spuVoiceTop.u_voiceCtrl.u_voiceAssert.failCount;
		$display("Errors: %0d mismatch, %0d timeout, %0d assertion, %0d other, %0d checked",
			mismatches, timeouts, assertFails, otherErrors, checkedOut);
		if ((mismatches + timeouts + assertFails + otherErrors) == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/voiceMonitor.sv */
// ****************************************
// Voice output checker
// Models ring, position and kernel per tick
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module voiceMonitor import voicePkg::*; (
	input  wire                         i_clk,
	input  wire                         i_rst,
	input  wire                         i_start,
	input  wire                         i_tick,
	input  wire        [PITCH_W-1:0]    i_pitch,
	input  wire                         i_wrEn,
	input  wire        [RING_ADR_W-1:0] i_wrAdr,
	input  wire signed [SAMPLE_W-1:0]   i_wrData,
	input  wire signed [SAMPLE_W-1:0]   i_sample,
	input  wire                         i_valid,
	input  wire                         i_tickLost,
	output int                          o_errCount,
	output int                          o_checked
);

	// Mirror of the 28 ring words
	logic signed [SAMPLE_W-1:0] ringModel [28];

	// Position as integer sample and 12 bit fraction
	int posInt;
	int posFrac;
	int fracSum;

	// Cycle count and run tracking
	int cyc;
	int acceptCyc;
	bit armed;
	bit running;
	bit startPrev;
	logic signed [SAMPLE_W-1:0] expSample;

	// B-spline weight for ROM entry k, 2^15 scale
	function automatic int ruleWeight(input int k);
		longint t;
		longint num;
		t = k % 256;
		if (k < 256) begin
			num = t * t * t;
		end else begin
			num = -3 * t * t * t + 768 * t * t + 196608 * t + 64'd16777216;
		end
		return int'((num * 32768) / (6 * 64'd16777216));
	endfunction

	// Expected output for one position and phase
	function automatic logic signed [SAMPLE_W-1:0] expectedSample(input int pos, input int phase);
		int i;
		int back;
		int romAdr;
		int ringAdr;
		logic signed [31:0] prod;
		logic signed [SAMPLE_W-1:0] term;
		logic signed [ACC_W-1:0] acc;
		acc = '0;
		for (i = 0; i < 4; i++) begin
			// Taps newest, old, oldest, older
			case (i)
				0: back = 0;
				1: back = 1;
				2: back = 3;
				default: back = 2;
			endcase
			// Odd taps use the upper half, the last two mirror the phase
			romAdr = ((i % 2) * 256) + ((i >= 2) ? (255 - phase) : phase);
			ringAdr = (pos - back + 32) % 32;
			// Block 7 reads block 6
			if (ringAdr >= 28) begin
				ringAdr = ringAdr - 4;
			end
			prod = ruleWeight(romAdr) * int'(ringModel[ringAdr]);
			term = prod[30:15];
			acc = acc + term;
		end
		return acc[SAMPLE_W-1:0];
	endfunction

	task automatic checkBit(input string name, input logic expVal, input logic gotVal);
		if (gotVal !== expVal) begin
			$display("Mismatch at %0t: %s expected %b got %b", $time, name, expVal, gotVal);
			o_errCount++;
		end
	endtask

	// Everything is sampled mid cycle, away from the driving edge
	always @(negedge i_clk) begin
		// Writes below 28 land in the ring, reset or not
		if (i_wrEn && (i_wrAdr < 5'd28)) begin
			ringModel[i_wrAdr] = i_wrData;
		end
		if (i_rst) begin
			posInt = 3;
			posFrac = 0;
			armed = 1'b0;
			running = 1'b0;
			startPrev = 1'b0;
			cyc = 0;
		end else begin
			cyc++;
			if (running) begin
				// Busy from go to one cycle after valid
				checkBit("o_tickLost", i_start && i_tick, i_tickLost);
				if (cyc - acceptCyc == 6) begin
					checkBit("o_valid", 1'b1, i_valid);
					if (i_sample !== expSample) begin
						$display("Mismatch at %0t: o_sample expected %0d got %0d",
							$time, expSample, i_sample);
						o_errCount++;
					end
					o_checked++;
				end else begin
					checkBit("o_valid", 1'b0, i_valid);
				end
				// Step in the cycle after the result
				if (cyc - acceptCyc == 7) begin
					fracSum = posFrac + int'(i_pitch);
					posInt = (posInt + fracSum / 4096) % 28;
					posFrac = fracSum % 4096;
					running = 1'b0;
					armed = i_start;
				end
			end else begin
				checkBit("o_valid", 1'b0, i_valid);
				checkBit("o_tickLost", 1'b0, i_tickLost);
				if (!armed) begin
					// Start edge reloads sample 3
					if (i_start && !startPrev) begin
						posInt = 3;
						posFrac = 0;
						armed = 1'b1;
					end
				end else if (!i_start) begin
					armed = 1'b0;
				end else if (i_tick) begin
					expSample = expectedSample(posInt, posFrac / 16);
					acceptCyc = cyc;
					running = 1'b1;
				end
			end
			startPrev = i_start;
		end
	end

endmodule

`default_nettype wire

/* testbench/voice_assert.sv */
// ****************************************
// Voice control FSM assertions
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module voice_assert (
	input wire i_clk,
	input wire i_rst,
	input wire i_go,
	input wire i_valid,
	input wire i_load,
	input wire i_step
);

	// Count of failed checks
	int failCount = 0;

	// Result is a single cycle pulse
	a_validPulse: assert property (@(posedge i_clk) disable iff (i_rst)
		i_valid |=> !i_valid)
		else begin
			$error("o_valid was high in two consecutive cycles");
			failCount++;
		end

	// Interpolator answers five cycles after go
	a_goToValid: assert property (@(posedge i_clk) disable iff (i_rst)
		i_go |-> ##5 i_valid)
		else begin
			$error("valid did not follow go after exactly 5 cycles");
			failCount++;
		end

	// Counter never loads and steps in one cycle
	a_loadStep: assert property (@(posedge i_clk) disable iff (i_rst)
		!(i_load && i_step))
		else begin
			$error("o_load and o_step were high together");
			failCount++;
		end

endmodule

`default_nettype wire
